// ==== tests/matrix_ctrl_stimulus.txt ====
# name  instruction  ptr_a  ptr_b  ptr_c  writes (instruction and pointers in hex, writes decimal)
# instruction: op[27:25] idx_a[24:21] idx_b[20:17] idx_c[16:13] sign[12] loop[11:6]
# pointer: bank in bits 13:12 above the port address
mac_n3       82460c0  0010  1020  2100  3
mac_n5_sign  88ad140  2040  3080  1200  5
nop_op3      6f13100  0001  1002  3003  0
mac_n1       9578040  1ffe  0005  3abc  1
nop_op0      1bde080  0100  1100  2100  0
mac_n7_sign  80251c0  3007  2009  0300  7
mac_n2       8246080  0010  1020  2100  2
nop_op7      e68a040  0200  1300  2300  0

// ==== list.f ====
+incdir+hdl
hdl/mcu_pkg.sv
hdl/inst_decoder.sv
hdl/uinst_rom.sv
hdl/useq.sv
hdl/agu.sv
hdl/mem_bus.sv
hdl/matrix_ctrl.sv
tests/matrix_ctrl_properties.sv
tests/tb_matrix_ctrl.sv

// ==== Bender.yml ====
package:
  name: matrix_ctrl

export_include_dirs:
  - hdl

sources:
  - hdl/mcu_pkg.sv
  - hdl/inst_decoder.sv
  - hdl/uinst_rom.sv
  - hdl/useq.sv
  - hdl/agu.sv
  - hdl/mem_bus.sv
  - hdl/matrix_ctrl.sv
  - target: test
    files:
      - tests/matrix_ctrl_properties.sv
      - tests/tb_matrix_ctrl.sv

// ==== tests/tb_matrix_ctrl.sv ====
`include "mcu_defines.svh"

module tb_matrix_ctrl;
    timeunit 1ns;
    timeprecision 100ps;

    localparam string STIM_FILE      = "tests/matrix_ctrl_stimulus.txt";
    localparam int    FINISH_TIMEOUT = 600;

    logic            clk;
    logic            rstn;
    logic            inst_valid;
    mcu_pkg::inst_t  inst;
    mcu_pkg::data_t  mem_rd_data_0, mem_rd_data_1, mem_rd_data_2, mem_rd_data_3;
    mcu_pkg::addr_t  mem_addr_0, mem_addr_1, mem_addr_2, mem_addr_3;
    logic            mem_wr_en_0, mem_wr_en_1, mem_wr_en_2, mem_wr_en_3;
    mcu_pkg::data_t  a_data, b_data, c_data;
    logic            macs_en;
    logic            macs_signal;
    logic            finish;

    // tests as read from the file
    string           names_q[$];
    mcu_pkg::inst_t  inst_q[$];
    mcu_pkg::ptr_t   ptr_a_q[$], ptr_b_q[$], ptr_c_q[$];
    int              writes_q[$];

    string           cur_name;
    mcu_pkg::inst_t  cur_inst;
    mcu_pkg::ptr_t   ptr_a, ptr_b, ptr_c;
    mcu_pkg::ptr_t   exp_d;
    int              exp_writes;
    mcu_pkg::data_t  table_next;
    mcu_pkg::data_t  rd_next [1:3];

    // monitor records cleared per test
    int              wr_port_q[$];
    mcu_pkg::addr_t  wr_addr_q[$];
    mcu_pkg::addr_t  a_addr_q[$];
    logic            sign_q[$];
    int              fin_count;

    int              err_count;
    int              check_count;
    int              test_errs;
    int              test_count;
    bit              aborted;

    matrix_ctrl matrix_ctrl_inst (
        .clk(clk), .rstn(rstn), .inst(inst), .inst_valid(inst_valid),
        .mem_rd_data_0(mem_rd_data_0), .mem_rd_data_1(mem_rd_data_1),
        .mem_rd_data_2(mem_rd_data_2), .mem_rd_data_3(mem_rd_data_3),
        .mem_addr_0(mem_addr_0), .mem_addr_1(mem_addr_1),
        .mem_addr_2(mem_addr_2), .mem_addr_3(mem_addr_3),
        .mem_wr_en_0(mem_wr_en_0), .mem_wr_en_1(mem_wr_en_1),
        .mem_wr_en_2(mem_wr_en_2), .mem_wr_en_3(mem_wr_en_3),
        .a_data(a_data), .b_data(b_data), .c_data(c_data),
        .macs_en(macs_en), .macs_signal(macs_signal), .finish(finish)
    );

    always #4 clk = ~clk;

    function automatic mcu_pkg::addr_t port_addr(int p);
        case (p)
            0:       return mem_addr_0;
            1:       return mem_addr_1;
            2:       return mem_addr_2;
            default: return mem_addr_3;
        endcase
    endfunction

    function automatic logic wr_en_at(int p);
        case (p)
            0:       return mem_wr_en_0;
            1:       return mem_wr_en_1;
            2:       return mem_wr_en_2;
            default: return mem_wr_en_3;
        endcase
    endfunction

    function automatic mcu_pkg::data_t rd_at(int p);
        case (p)
            0:       return mem_rd_data_0;
            1:       return mem_rd_data_1;
            2:       return mem_rd_data_2;
            default: return mem_rd_data_3;
        endcase
    endfunction

    // only the three indices of the running test hold pointers
    function automatic mcu_pkg::data_t table_read(mcu_pkg::addr_t addr);
        if (addr == mcu_pkg::addr_t'(cur_inst[`F_IDX_A])) return mcu_pkg::data_t'(ptr_a);
        if (addr == mcu_pkg::addr_t'(cur_inst[`F_IDX_B])) return mcu_pkg::data_t'(ptr_b);
        if (addr == mcu_pkg::addr_t'(cur_inst[`F_IDX_C])) return mcu_pkg::data_t'(ptr_c);
        return '0;
    endfunction

    // port number and whole port address, never zero
    function automatic mcu_pkg::data_t fill_word(int p, mcu_pkg::addr_t addr);
        return {8'(p), 8'ha5, 4'h0, addr, 8'(p), 8'h5a, 4'h0, ~addr};
    endfunction

    always @(negedge clk) begin
        table_next = table_read(mem_addr_0);
        for (int p = 1; p < 4; p++) begin
            rd_next[p] = fill_word(p, port_addr(p));
        end
    end

    always @(posedge clk) begin
        #1;
        mem_rd_data_0 = table_next;   // data one cycle after the address
        mem_rd_data_1 = rd_next[1];
        mem_rd_data_2 = rd_next[2];
        mem_rd_data_3 = rd_next[3];
    end

    always @(negedge clk) begin
        if (rstn) begin
            for (int p = 0; p < 4; p++) begin
                if (wr_en_at(p)) begin
                    wr_port_q.push_back(p);
                    wr_addr_q.push_back(port_addr(p));
                end
            end
            if (macs_en) begin
                a_addr_q.push_back(port_addr(ptr_a[`PTR_WIDTH-1:`ADDR_WIDTH]));
                sign_q.push_back(macs_signal);
                check_value("a_data", rd_at(ptr_a[`PTR_WIDTH-1:`ADDR_WIDTH]), a_data);
                check_value("b_data", rd_at(ptr_b[`PTR_WIDTH-1:`ADDR_WIDTH]), b_data);
                check_value("c_data", rd_at(ptr_c[`PTR_WIDTH-1:`ADDR_WIDTH]), c_data);
            end
            if (finish) fin_count++;
        end
    end

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (expected !== actual) begin
            $display("error %s %s: expected %0h, actual %0h", cur_name, what, expected, actual);
            test_errs++;
            err_count++;
        end
    endtask

    task automatic read_stimulus();
        int             fd;
        int             n;
        int             nw;
        string          line;
        string          nm;
        mcu_pkg::inst_t iw;
        mcu_pkg::ptr_t  pa, pb, pc;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", STIM_FILE);
            err_count++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%s %h %h %h %h %d", nm, iw, pa, pb, pc, nw);
                if (n == 6) begin
                    names_q.push_back(nm);
                    inst_q.push_back(iw);
                    ptr_a_q.push_back(pa);
                    ptr_b_q.push_back(pb);
                    ptr_c_q.push_back(pc);
                    writes_q.push_back(nw);
                end else begin
                    $display("stimulus line could not be parsed: %s", line);
                    err_count++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic clear_records();
        wr_port_q.delete();
        wr_addr_q.delete();
        a_addr_q.delete();
        sign_q.delete();
        fin_count = 0;
        test_errs = 0;
    endtask

    task automatic load_test(int t);
        cur_name   = names_q[t];
        cur_inst   = inst_q[t];
        ptr_a      = ptr_a_q[t];
        ptr_b      = ptr_b_q[t];
        ptr_c      = ptr_c_q[t];
        exp_writes = writes_q[t];
        exp_d      = ptr_c ^ (mcu_pkg::ptr_t'(1) << `ADDR_WIDTH);   // other port of c's bank
        clear_records();
        inst       = cur_inst;
        inst_valid = 1'b1;
    endtask

    task automatic wait_finish(output bit ok);
        int cycles;
        cycles = 0;
        while (fin_count == 0 && cycles < FINISH_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        ok = (fin_count != 0);
        if (ok) @(posedge clk);   // idle cycle after finish still counts for this test
        #1;
    endtask

    task automatic finish_test();
        check_value("finish pulses", 1, fin_count);
        check_value("write count", exp_writes, wr_port_q.size());
        check_value("macs_en cycles", `INNER_LOOP * exp_writes, a_addr_q.size());
        foreach (wr_port_q[k]) begin
            check_value("write port", exp_d[`PTR_WIDTH-1:`ADDR_WIDTH], wr_port_q[k]);
            check_value("write address", mcu_pkg::addr_t'(exp_d[`ADDR_WIDTH-1:0] + k),
                        wr_addr_q[k]);
        end
        foreach (a_addr_q[k]) begin
            check_value("a address", mcu_pkg::addr_t'(ptr_a[`ADDR_WIDTH-1:0] + k), a_addr_q[k]);
            check_value("macs_signal", cur_inst[`F_SIGN], sign_q[k]);
        end
        test_count++;
        if (test_errs == 0) $display("test %s ok", cur_name);
        else $display("test %s FAIL with %0d errors", cur_name, test_errs);
    endtask

    // nothing may move while no instruction is offered
    task automatic quiet_check();
        cur_name   = "idle";
        inst_valid = 1'b0;
        clear_records();
        repeat (10) @(posedge clk);
        check_value("finish pulses", 0, fin_count);
        check_value("write count", 0, wr_port_q.size());
        check_value("macs_en cycles", 0, a_addr_q.size());
        test_count++;
        if (test_errs == 0) $display("test %s ok", cur_name);
        else $display("test %s FAIL with %0d errors", cur_name, test_errs);
    endtask

    initial begin
        bit ok;
        clk           = 1'b0;
        rstn          = 1'b0;
        inst          = '0;
        inst_valid    = 1'b0;
        mem_rd_data_0 = '0;
        mem_rd_data_1 = '0;
        mem_rd_data_2 = '0;
        mem_rd_data_3 = '0;
        table_next    = '0;
        for (int p = 1; p < 4; p++) begin
            rd_next[p] = '0;
        end
        cur_inst      = '0;
        ptr_a         = '0;
        ptr_b         = '0;
        ptr_c         = '0;
        read_stimulus();
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;
        for (int t = 0; t < names_q.size() && !aborted; t++) begin
            load_test(t);   // next instruction is ready before the following fetch
            wait_finish(ok);
            if (ok) begin
                finish_test();
            end else begin
                $display("timeout: no finish from test %s within %0d cycles",
                         cur_name, FINISH_TIMEOUT);
                err_count++;
                aborted = 1'b1;
            end
        end
        if (!aborted) quiet_check();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        if (err_count == 0 && test_count > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== tests/matrix_ctrl_properties.sv ====
module matrix_ctrl_properties (
    input logic clk,
    input logic rstn,
    input logic mem_wr_en_0,
    input logic mem_wr_en_1,
    input logic mem_wr_en_2,
    input logic mem_wr_en_3,
    input logic macs_en,
    input logic finish
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [3:0] wr_en;

    assign wr_en = {mem_wr_en_3, mem_wr_en_2, mem_wr_en_1, mem_wr_en_0};

    wr_one_port: assert property (@(posedge clk) disable iff (!rstn) $onehot0(wr_en))
        else $error("more than one write enable high: %b", wr_en);

    finish_pulse: assert property (@(posedge clk) disable iff (!rstn) finish |=> !finish)
        else $error("finish high for two cycles");

    // strobes stay low under reset
    quiet_in_reset: assert property (@(posedge clk) !rstn |-> (!macs_en && wr_en == 4'b0))
        else $error("macs_en or a write enable high during reset");

endmodule

bind matrix_ctrl matrix_ctrl_properties matrix_ctrl_properties_inst (
    .clk(clk), .rstn(rstn),
    .mem_wr_en_0(mem_wr_en_0), .mem_wr_en_1(mem_wr_en_1),
    .mem_wr_en_2(mem_wr_en_2), .mem_wr_en_3(mem_wr_en_3),
    .macs_en(macs_en), .finish(finish)
);

// ==== hdl/matrix_ctrl.sv ====
`include "mcu_defines.svh"

module matrix_ctrl (
    input  logic            clk,
    input  logic            rstn,
    input  mcu_pkg::inst_t  inst,
    input  logic            inst_valid,
    input  mcu_pkg::data_t  mem_rd_data_0,
    input  mcu_pkg::data_t  mem_rd_data_1,
    input  mcu_pkg::data_t  mem_rd_data_2,
    input  mcu_pkg::data_t  mem_rd_data_3,
    output mcu_pkg::addr_t  mem_addr_0,
    output mcu_pkg::addr_t  mem_addr_1,
    output mcu_pkg::addr_t  mem_addr_2,
    output mcu_pkg::addr_t  mem_addr_3,
    output logic            mem_wr_en_0,
    output logic            mem_wr_en_1,
    output logic            mem_wr_en_2,
    output logic            mem_wr_en_3,
    output mcu_pkg::data_t  a_data,
    output mcu_pkg::data_t  b_data,
    output mcu_pkg::data_t  c_data,
    output logic            macs_en,
    output logic            macs_signal,
    output logic            finish
);

    mcu_pkg::addr_t  table_addr;
    logic            table_en;
    mcu_pkg::ptr_t   a_start, b_start, c_start, d_start;
    mcu_pkg::ptr_t   a_ptr, b_ptr, c_ptr, d_ptr;
    logic            ptr_load;
    logic [3:0]      wen_sel;
    logic [2:0]      opcode;
    mcu_pkg::loop_t  loop_0, loop_1;
    logic            exec;
    mcu_pkg::upc_t   upc;
    mcu_pkg::uinst_t uinst;
    logic            inc_a, inc_b, inc_c, inc_d;
    logic            mem_wen;

    // write strobe lands only on d's port
    assign mem_wr_en_0 = mem_wen & wen_sel[0];
    assign mem_wr_en_1 = mem_wen & wen_sel[1];
    assign mem_wr_en_2 = mem_wen & wen_sel[2];
    assign mem_wr_en_3 = mem_wen & wen_sel[3];

    inst_decoder inst_decoder_inst (
        .clk(clk), .rstn(rstn), .inst(inst), .inst_valid(inst_valid),
        .table_data(mem_rd_data_0), .done(finish),
        .table_addr(table_addr), .table_en(table_en),
        .a_start(a_start), .b_start(b_start), .c_start(c_start), .d_start(d_start),
        .ptr_load(ptr_load), .wen_sel(wen_sel), .opcode(opcode),
        .loop_0(loop_0), .loop_1(loop_1), .exec(exec), .macs_signal(macs_signal)
    );

    useq useq_inst (
        .clk(clk), .rstn(rstn), .exec(exec), .opcode(opcode),
        .loop_0(loop_0), .loop_1(loop_1), .uinst(uinst), .upc(upc),
        .inc_a(inc_a), .inc_b(inc_b), .inc_c(inc_c), .inc_d(inc_d),
        .mac_en(macs_en), .mem_wen(mem_wen), .done(finish)
    );

    uinst_rom uinst_rom_inst (
        .clk(clk), .upc(upc), .uinst(uinst)
    );

    agu agu_inst (
        .clk(clk), .rstn(rstn), .ptr_load(ptr_load),
        .a_start(a_start), .b_start(b_start), .c_start(c_start), .d_start(d_start),
        .inc_a(inc_a), .inc_b(inc_b), .inc_c(inc_c), .inc_d(inc_d),
        .a_ptr(a_ptr), .b_ptr(b_ptr), .c_ptr(c_ptr), .d_ptr(d_ptr)
    );

    mem_bus mem_bus_inst (
        .table_addr(table_addr), .table_en(table_en),
        .a_ptr(a_ptr), .b_ptr(b_ptr), .c_ptr(c_ptr), .d_ptr(d_ptr),
        .rd_data_0(mem_rd_data_0), .rd_data_1(mem_rd_data_1),
        .rd_data_2(mem_rd_data_2), .rd_data_3(mem_rd_data_3),
        .mem_addr_0(mem_addr_0), .mem_addr_1(mem_addr_1),
        .mem_addr_2(mem_addr_2), .mem_addr_3(mem_addr_3),
        .a_data(a_data), .b_data(b_data), .c_data(c_data)
    );

endmodule

// ==== hdl/mem_bus.sv ====
`include "mcu_defines.svh"

module mem_bus (
    input  mcu_pkg::addr_t  table_addr,
    input  logic            table_en,
    input  mcu_pkg::ptr_t   a_ptr,
    input  mcu_pkg::ptr_t   b_ptr,
    input  mcu_pkg::ptr_t   c_ptr,
    input  mcu_pkg::ptr_t   d_ptr,
    input  mcu_pkg::data_t  rd_data_0,
    input  mcu_pkg::data_t  rd_data_1,
    input  mcu_pkg::data_t  rd_data_2,
    input  mcu_pkg::data_t  rd_data_3,
    output mcu_pkg::addr_t  mem_addr_0,
    output mcu_pkg::addr_t  mem_addr_1,
    output mcu_pkg::addr_t  mem_addr_2,
    output mcu_pkg::addr_t  mem_addr_3,
    output mcu_pkg::data_t  a_data,
    output mcu_pkg::data_t  b_data,
    output mcu_pkg::data_t  c_data
);

    mcu_pkg::ptr_t  ptr_v [4];
    mcu_pkg::addr_t addr_v [4];
    mcu_pkg::data_t rd_v [4];

    assign ptr_v[0] = a_ptr;
    assign ptr_v[1] = b_ptr;
    assign ptr_v[2] = c_ptr;
    assign ptr_v[3] = d_ptr;
    assign rd_v[0]  = rd_data_0;
    assign rd_v[1]  = rd_data_1;
    assign rd_v[2]  = rd_data_2;
    assign rd_v[3]  = rd_data_3;

    // later pointers overwrite earlier ones so d wins, then c, b, a
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            addr_v[p] = '0;
            for (int s = 0; s < 4; s++) begin
                if (ptr_v[s][`PTR_WIDTH-1:`ADDR_WIDTH] == 2'(p)) begin
                    addr_v[p] = ptr_v[s][`ADDR_WIDTH-1:0];
                end
            end
        end
        if (table_en) addr_v[0] = table_addr;   // control table sits on bank 0 port 0
    end

    assign mem_addr_0 = addr_v[0];
    assign mem_addr_1 = addr_v[1];
    assign mem_addr_2 = addr_v[2];
    assign mem_addr_3 = addr_v[3];

    assign a_data = rd_v[a_ptr[`PTR_WIDTH-1:`ADDR_WIDTH]];
    assign b_data = rd_v[b_ptr[`PTR_WIDTH-1:`ADDR_WIDTH]];
    assign c_data = rd_v[c_ptr[`PTR_WIDTH-1:`ADDR_WIDTH]];

endmodule

// ==== hdl/agu.sv ====
`include "mcu_defines.svh"

module agu (
    input  logic            clk,
    input  logic            rstn,
    input  logic            ptr_load,
    input  mcu_pkg::ptr_t   a_start,
    input  mcu_pkg::ptr_t   b_start,
    input  mcu_pkg::ptr_t   c_start,
    input  mcu_pkg::ptr_t   d_start,
    input  logic            inc_a,
    input  logic            inc_b,
    input  logic            inc_c,
    input  logic            inc_d,
    output mcu_pkg::ptr_t   a_ptr,
    output mcu_pkg::ptr_t   b_ptr,
    output mcu_pkg::ptr_t   c_ptr,
    output mcu_pkg::ptr_t   d_ptr
);

    mcu_pkg::ptr_t start_v [4];
    mcu_pkg::ptr_t ptr_q [4];
    logic [3:0]    inc;

    assign start_v[0] = a_start;
    assign start_v[1] = b_start;
    assign start_v[2] = c_start;
    assign start_v[3] = d_start;
    assign inc        = {inc_d, inc_c, inc_b, inc_a};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int k = 0; k < 4; k++) ptr_q[k] <= '0;
        end else begin
            for (int k = 0; k < 4; k++) begin
                if (ptr_load) begin
                    ptr_q[k] <= start_v[k];
                end else if (inc[k]) begin
                    ptr_q[k][`ADDR_WIDTH-1:0] <= ptr_q[k][`ADDR_WIDTH-1:0] + 1'b1;  // bank kept
                end
            end
        end
    end

    assign a_ptr = ptr_q[0];
    assign b_ptr = ptr_q[1];
    assign c_ptr = ptr_q[2];
    assign d_ptr = ptr_q[3];

endmodule

// ==== hdl/useq.sv ====
`include "mcu_defines.svh"

module useq (
    input  logic              clk,
    input  logic              rstn,
    input  logic              exec,
    input  logic [2:0]        opcode,
    input  mcu_pkg::loop_t    loop_0,
    input  mcu_pkg::loop_t    loop_1,
    input  mcu_pkg::uinst_t   uinst,
    output mcu_pkg::upc_t     upc,
    output logic              inc_a,
    output logic              inc_b,
    output logic              inc_c,
    output logic              inc_d,
    output logic              mac_en,
    output logic              mem_wen,
    output logic              done
);

    logic            exec_q;
    logic            start;
    logic            run;       // a fetched microword is live
    mcu_pkg::upc_t   cur_pc;    // address of the word now on uinst
    mcu_pkg::upc_t   loop_start [2];
    mcu_pkg::loop_t  loop_rem [2];
    mcu_pkg::loop_t  loop_cnt [2];
    logic [1:0]      mark;
    logic [1:0]      take;

    assign start       = exec & ~exec_q;
    assign loop_cnt[0] = loop_0;
    assign loop_cnt[1] = loop_1;
    assign mark        = {uinst[`U_MARK_1], uinst[`U_MARK_0]} & {2{run}};
    assign take[1]     = run & uinst[`U_BACK_1] & (loop_rem[1] != '0);
    assign take[0]     = run & uinst[`U_BACK_0] & (loop_rem[0] != '0) & ~take[1];

    // rom adds one cycle of latency to this fetch address
    always_comb begin
        if (start) begin
            upc = (opcode == `OP_MAC) ? mcu_pkg::upc_t'(`MAC_ENTRY) : '0;
        end else if (!run) begin
            upc = cur_pc;
        end else if (take[1]) begin
            upc = loop_start[1];
        end else if (take[0]) begin
            upc = loop_start[0];
        end else begin
            upc = cur_pc + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            exec_q <= 1'b0;
            run    <= 1'b0;
            cur_pc <= '0;
            for (int k = 0; k < 2; k++) begin
                loop_start[k] <= '0;
                loop_rem[k]   <= '0;
            end
        end else begin
            exec_q <= exec;
            run    <= start | (run & ~done);
            cur_pc <= upc;
            for (int k = 0; k < 2; k++) begin
                if (mark[k]) begin
                    loop_start[k] <= cur_pc + 1'b1;   // body follows the mark word
                    loop_rem[k]   <= loop_cnt[k] - 1'b1;
                end else if (take[k]) begin
                    loop_rem[k] <= loop_rem[k] - 1'b1;
                end
            end
        end
    end

    assign inc_a   = run & uinst[`U_INC_A];
    assign inc_b   = run & uinst[`U_INC_B];
    assign inc_c   = run & uinst[`U_INC_C];
    assign inc_d   = run & uinst[`U_INC_D];
    assign mac_en  = run & uinst[`U_MAC];
    assign mem_wen = run & uinst[`U_WEN];
    assign done    = run & uinst[`U_DONE];

endmodule

// ==== hdl/uinst_rom.sv ====
`include "mcu_defines.svh"

module uinst_rom (
    input  logic              clk,
    input  mcu_pkg::upc_t     upc,
    output mcu_pkg::uinst_t   uinst
);

    mcu_pkg::uinst_t word;

    always_comb begin
        word = '0;
        case (upc)
            0: word[`U_DONE] = 1'b1;   // unknown opcode finishes at once
            `MAC_ENTRY: word[`U_MARK_0] = 1'b1;
            `MAC_ENTRY + 1: word[`U_MARK_1] = 1'b1;
            `MAC_ENTRY + 2: begin
                word[`U_MAC]    = 1'b1;
                word[`U_INC_A]  = 1'b1;
                word[`U_INC_B]  = 1'b1;
                word[`U_BACK_1] = 1'b1;
            end
            `MAC_ENTRY + 3: begin
                word[`U_WEN]    = 1'b1;   // one result per outer pass
                word[`U_INC_C]  = 1'b1;
                word[`U_INC_D]  = 1'b1;
                word[`U_BACK_0] = 1'b1;
            end
            `MAC_ENTRY + 4: word[`U_DONE] = 1'b1;
            default: word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        uinst <= word;
    end

endmodule

// ==== hdl/inst_decoder.sv ====
`include "mcu_defines.svh"

module inst_decoder (
    input  logic                clk,
    input  logic                rstn,
    input  mcu_pkg::inst_t      inst,
    input  logic                inst_valid,
    input  mcu_pkg::data_t      table_data,
    input  logic                done,
    output mcu_pkg::addr_t      table_addr,
    output logic                table_en,
    output mcu_pkg::ptr_t       a_start,
    output mcu_pkg::ptr_t       b_start,
    output mcu_pkg::ptr_t       c_start,
    output mcu_pkg::ptr_t       d_start,
    output logic                ptr_load,
    output logic [3:0]          wen_sel,
    output logic [2:0]          opcode,
    output mcu_pkg::loop_t      loop_0,
    output mcu_pkg::loop_t      loop_1,
    output logic                exec,
    output logic                macs_signal
);

    mcu_pkg::ctrl_state_t state, next_state;
    mcu_pkg::inst_t       inst_reg;
    logic [2:0]           dec_cnt;
    logic                 dec_last;

    assign opcode   = inst_reg[`F_OP];
    assign dec_last = (state == mcu_pkg::ST_DECODE) && (dec_cnt == 3'(`DECODE_CYCLES - 1));
    assign ptr_load = dec_last;   // agu picks up the pointers on entry to execute
    assign exec     = (state == mcu_pkg::ST_EXEC);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= mcu_pkg::ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            mcu_pkg::ST_IDLE:   next_state = mcu_pkg::ST_FETCH;
            mcu_pkg::ST_FETCH:  if (inst_valid) next_state = mcu_pkg::ST_DECODE;
            mcu_pkg::ST_DECODE: if (dec_last) next_state = mcu_pkg::ST_EXEC;
            mcu_pkg::ST_EXEC:   if (done) next_state = mcu_pkg::ST_IDLE;
            default:            next_state = mcu_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            inst_reg <= '0;
            dec_cnt  <= '0;
        end else begin
            if (state == mcu_pkg::ST_IDLE) begin
                inst_reg <= '0;
            end else if (state == mcu_pkg::ST_FETCH && inst_valid) begin
                inst_reg <= inst;
            end
            dec_cnt <= (state == mcu_pkg::ST_DECODE) ? dec_cnt + 3'd1 : 3'd0;
        end
    end

    // table reads return one cycle after the address register updates
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            table_addr <= '0;
            table_en   <= 1'b0;
            a_start    <= '0;
            b_start    <= '0;
            c_start    <= '0;
            d_start    <= '0;
            wen_sel    <= '0;
        end else if (state == mcu_pkg::ST_IDLE) begin
            table_addr <= '0;
            table_en   <= 1'b0;
            a_start    <= '0;
            b_start    <= '0;
            c_start    <= '0;
            d_start    <= '0;
            wen_sel    <= '0;
        end else if (state == mcu_pkg::ST_DECODE) begin
            case (dec_cnt)
                3'd0: begin
                    table_addr <= mcu_pkg::addr_t'(inst_reg[`F_IDX_A]);
                    table_en   <= 1'b1;
                end
                3'd1: table_addr <= mcu_pkg::addr_t'(inst_reg[`F_IDX_B]);
                3'd2: begin
                    table_addr <= mcu_pkg::addr_t'(inst_reg[`F_IDX_C]);
                    a_start    <= table_data[`PTR_WIDTH-1:0];
                end
                3'd3: begin
                    b_start  <= table_data[`PTR_WIDTH-1:0];
                    table_en <= 1'b0;
                end
                3'd4: begin
                    c_start <= table_data[`PTR_WIDTH-1:0];
                    d_start <= {table_data[`PTR_WIDTH-1], ~table_data[`ADDR_WIDTH],
                                table_data[`ADDR_WIDTH-1:0]};  // other port of c's bank
                end
                3'd5: wen_sel <= 4'b0001 << d_start[`PTR_WIDTH-1:`ADDR_WIDTH];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            loop_0      <= '0;
            loop_1      <= '0;
            macs_signal <= 1'b0;
        end else if (state == mcu_pkg::ST_IDLE) begin
            loop_0      <= '0;
            loop_1      <= '0;
            macs_signal <= 1'b0;
        end else if (state == mcu_pkg::ST_DECODE && dec_cnt == 3'd0 && opcode == `OP_MAC) begin
            loop_0      <= mcu_pkg::loop_t'(inst_reg[`F_LOOP]);   // outer count from immediate
            loop_1      <= mcu_pkg::loop_t'(`INNER_LOOP);
            macs_signal <= inst_reg[`F_SIGN];
        end
    end

endmodule

// ==== hdl/mcu_pkg.sv ====
`include "mcu_defines.svh"

package mcu_pkg;

    typedef logic [`INST_WIDTH-1:0]       inst_t;
    typedef logic [`ADDR_WIDTH-1:0]       addr_t;
    typedef logic [`PTR_WIDTH-1:0]        ptr_t;
    typedef logic [`DATA_WIDTH-1:0]       data_t;
    typedef logic [`UINST_ADDR_WIDTH-1:0] upc_t;
    typedef logic [`UINST_WIDTH-1:0]      uinst_t;
    typedef logic [`LOOP_WIDTH-1:0]       loop_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_DECODE,
        ST_EXEC
    } ctrl_state_t;

endpackage

// ==== hdl/mcu_defines.svh ====
`ifndef MCU_DEFINES_SVH
`define MCU_DEFINES_SVH

`define INST_WIDTH       28
`define ADDR_WIDTH       12
`define PTR_WIDTH        (`ADDR_WIDTH + 2)   // bank select above port address
`define DATA_WIDTH       64
`define UINST_ADDR_WIDTH 6
`define UINST_WIDTH      14
`define LOOP_WIDTH       11

// opcodes and microprogram entry points
`define OP_MAC           3'b100
`define MAC_ENTRY        4
`define INNER_LOOP       2
`define DECODE_CYCLES    6

// instruction fields
`define F_OP             27:25
`define F_IDX_A          24:21
`define F_IDX_B          20:17
`define F_IDX_C          16:13
`define F_SIGN           12
`define F_LOOP           11:6

// microword bits with 11..13 spare
`define U_DONE           0
`define U_MARK_0         1
`define U_MARK_1         2
`define U_BACK_0         3
`define U_BACK_1         4
`define U_MAC            5
`define U_WEN            6
`define U_INC_A          7
`define U_INC_B          8
`define U_INC_C          9
`define U_INC_D          10

`endif
